/* cf_spi_top.f */
+incdir+verilog
verilog/cf_spi_regs_pkg.sv
verilog/cf_spi_xfer_pkg.sv
verilog/cf_spi_up_regs.sv
verilog/cf_spi_engine.sv
verilog/cf_spi_top.sv
test/cf_spi_props.sv
test/cf_spi_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= cf_spi_tb
FILELIST  ?= cf_spi_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert

FAIL_MSG := SOME TESTS FAILED
PASS_MSG := ALL TESTS PASSED
SIM_BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* test/cf_spi_tb.sv */
`default_nettype none

`include "cf_spi_settings.svh"

module cf_spi_tb;

  import cf_spi_regs_pkg::*;
  import cf_spi_xfer_pkg::*;

  localparam int CLK_HALF   = 4;
  localparam int ACK_LIMIT  = 8;
  // enough status polls for a 32-bit frame with chip select margins.
  localparam int POLL_LIMIT = 40 << `CF_SPI_CLK_DIV_LOG2;
  localparam int N_XFER     = 6;

  typedef struct packed {
    dev_sel_e    dev;
    logic [31:0] word;
    logic [7:0]  ret;
  } xfer_entry_t;

  logic                      up_clk;
  logic                      up_rstn;
  logic                      up_req_i;
  bus_op_e                   up_op_i;
  reg_addr_e                 up_addr_i;
  logic [`CF_SPI_DATA_W-1:0] up_wdata_i;
  wire                       up_ack_o;
  wire  [`CF_SPI_DATA_W-1:0] up_rdata_o;
  wire                       spi_cs0n_o;
  wire                       spi_cs1n_o;
  wire                       spi_clk_o;
  wire                       spi_sd_o;
  logic                      spi_sd_i;

  xfer_entry_t               stim [N_XFER];
  logic [7:0]                ret_byte;
  logic [31:0]               rx_frame;
  int                        rx_bits;
  int                        frame_cnt;
  logic                      cs0_seen;
  logic                      cs1_seen;
  logic [`CF_SPI_DATA_W-1:0] exp_rdata;

  cf_spi_top i_cf_spi_top (
    .up_clk     (up_clk),
    .up_rstn    (up_rstn),
    .up_req_i   (up_req_i),
    .up_op_i    (up_op_i),
    .up_addr_i  (up_addr_i),
    .up_wdata_i (up_wdata_i),
    .up_ack_o   (up_ack_o),
    .up_rdata_o (up_rdata_o),
    .spi_cs0n_o (spi_cs0n_o),
    .spi_cs1n_o (spi_cs1n_o),
    .spi_clk_o  (spi_clk_o),
    .spi_sd_o   (spi_sd_o),
    .spi_sd_i   (spi_sd_i)
  );

  initial begin
    up_clk = 1'b0;
    forever #CLK_HALF up_clk = ~up_clk;
  end

  // the device model takes one frame per chip select low period and samples on rising edges.
  initial begin
    frame_cnt = 0;
    rx_frame  = '0;
    rx_bits   = 0;
    cs0_seen  = 1'b0;
    cs1_seen  = 1'b0;
    forever begin
      @(negedge spi_cs0n_o or negedge spi_cs1n_o);
      cs0_seen = !spi_cs0n_o;
      cs1_seen = !spi_cs1n_o;
      rx_frame = '0;
      rx_bits  = 0;
      while (!spi_cs0n_o || !spi_cs1n_o) begin
        @(posedge spi_clk_o or posedge spi_cs0n_o or posedge spi_cs1n_o);
        if (spi_clk_o === 1'b1) begin
          rx_frame = {rx_frame[30:0], spi_sd_o};
          rx_bits++;
        end
      end
      frame_cnt++;
    end
  end

  // a device 0 read answers MSB first during the last 8 bits of its frame.
  initial begin
    spi_sd_i = 1'b0;
    forever begin
      @(negedge spi_clk_o);
      #1;
      if (!spi_cs0n_o && rx_bits >= 8 && rx_bits < 16 && rx_frame[rx_bits-1]) begin
        spi_sd_i = ret_byte[15-rx_bits];
      end
    end
  end

  task automatic abort_run();
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic wait_ack(input logic level, input string what);
    int n;
    n = 0;
    while (up_ack_o !== level) begin
      if (n == ACK_LIMIT) begin
        $display("timeout: %s", what);
        abort_run();
      end
      @(posedge up_clk);
      #1;
      n++;
    end
  endtask

  task automatic bus_write(input reg_addr_e addr, input logic [`CF_SPI_DATA_W-1:0] data);
    @(posedge up_clk);
    #1;
    up_op_i    = OP_WRITE;
    up_addr_i  = addr;
    up_wdata_i = data;
    up_req_i   = 1'b1;
    wait_ack(1'b1, "host write was never acknowledged");
    up_req_i = 1'b0;
    wait_ack(1'b0, "host ack stayed high after a write");
  endtask

  task automatic bus_read(input reg_addr_e addr, output logic [`CF_SPI_DATA_W-1:0] data);
    @(posedge up_clk);
    #1;
    up_op_i   = OP_READ;
    up_addr_i = addr;
    up_req_i  = 1'b1;
    wait_ack(1'b1, "host read was never acknowledged");
    data     = up_rdata_o;
    up_req_i = 1'b0;
    wait_ack(1'b0, "host ack stayed high after a read");
  endtask

  task automatic wait_idle();
    logic [`CF_SPI_DATA_W-1:0] status;
    int                        n;
    n      = 0;
    status = 1;
    while (status[0] !== 1'b0) begin
      if (n == POLL_LIMIT) begin
        $display("timeout: the transfer never finished, busy stayed set");
        abort_run();
      end
      bus_read(REG_STATUS, status);
      n++;
    end
  endtask

  task automatic check_reg(input string name, input logic [`CF_SPI_DATA_W-1:0] exp,
                           input logic [`CF_SPI_DATA_W-1:0] act);
    if (act !== exp) begin
      $display("FAIL time=%0t %s expected=%h actual=%h", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_frame(input int exp_cnt, input logic [31:0] exp_frame, input int exp_bits);
    if (frame_cnt != exp_cnt) begin
      $display("FAIL time=%0t frame_cnt expected=%0d actual=%0d", $time, exp_cnt, frame_cnt);
      abort_run();
    end
    if (rx_bits != exp_bits) begin
      $display("FAIL time=%0t rx_bits expected=%0d actual=%0d", $time, exp_bits, rx_bits);
      abort_run();
    end
    if (rx_frame !== exp_frame) begin
      $display("FAIL time=%0t rx_frame expected=%h actual=%h", $time, exp_frame, rx_frame);
      abort_run();
    end
  endtask

  task automatic check_dev(input dev_sel_e exp);
    dev_sel_e act;
    if (cs0_seen == cs1_seen) begin
      $display("error: not exactly one chip select went low during the last frame");
      abort_run();
    end
    act = cs1_seen ? DEV_1 : DEV_0;
    if (act !== exp) begin
      $display("FAIL time=%0t spi_cs_n expected=%s actual=%s", $time, exp.name(), act.name());
      abort_run();
    end
  endtask

  task automatic run_xfer(input xfer_entry_t e);
    logic [`CF_SPI_DATA_W-1:0] rd;
    logic [31:0]               exp_frame;
    int                        exp_bits;
    int                        frames_before;
    frames_before = frame_cnt;
    ret_byte      = e.ret;
    if (e.dev == DEV_1) begin
      exp_frame = e.word;
      exp_bits  = 32;
      bus_write(REG_WDATA1, e.word);
    end else begin
      exp_frame = {16'd0, e.word[15:0]};
      exp_bits  = 16;
      bus_write(REG_WDATA0, e.word);
      // only a read frame replaces the read-back byte.
      if (e.word[15]) begin
        exp_rdata = {24'd0, e.ret};
      end
    end
    bus_write(REG_CTRL, {31'd0, e.dev});
    wait_idle();
    check_frame(frames_before + 1, exp_frame, exp_bits);
    check_dev(e.dev);
    bus_read(REG_RDATA, rd);
    check_reg("REG_RDATA", exp_rdata, rd);
  endtask

  initial begin
    logic [`CF_SPI_DATA_W-1:0] rd;
    logic [`CF_SPI_DATA_W-1:0] first;
    int                        frames_before;
    void'($urandom(57));
    up_rstn    = 1'b0;
    up_req_i   = 1'b0;
    up_op_i    = OP_READ;
    up_addr_i  = REG_WDATA0;
    up_wdata_i = '0;
    ret_byte   = '0;
    exp_rdata  = '0;
    // device 0 words with bit 15 set are reads, the others are writes.
    stim[0] = '{dev: DEV_1, word: 32'hA5C3_0F96, ret: 8'h00};
    stim[1] = '{dev: DEV_0, word: 32'h0000_81F0, ret: 8'hB7};
    stim[2] = '{dev: DEV_0, word: 32'h0000_3C5A, ret: 8'h4E};
    stim[3] = '{dev: DEV_1, word: $urandom(), ret: 8'h00};
    stim[4] = '{dev: DEV_0, word: {16'd0, 1'b1, 15'($urandom())}, ret: 8'($urandom())};
    stim[5] = '{dev: DEV_0, word: {16'd0, 1'b0, 15'($urandom())}, ret: 8'($urandom())};
    repeat (3) @(posedge up_clk);
    #1;
    up_rstn = 1'b1;

    bus_read(REG_STATUS, rd);
    check_reg("REG_STATUS", '0, rd);
    bus_read(REG_RDATA, rd);
    check_reg("REG_RDATA", '0, rd);
    check_reg("spi_cs_n", 32'd3, {30'd0, spi_cs1n_o, spi_cs0n_o});
    first = $urandom();
    bus_write(REG_WDATA0, first);
    bus_read(REG_WDATA0, rd);
    check_reg("REG_WDATA0", {16'd0, first[15:0]}, rd);
    bus_write(REG_WDATA1, ~first);
    bus_read(REG_WDATA1, rd);
    check_reg("REG_WDATA1", ~first, rd);

    for (int i = 0; i < N_XFER; i++) begin
      run_xfer(stim[i]);
    end

    // a second start while busy must not produce another frame.
    first         = $urandom();
    frames_before = frame_cnt;
    bus_write(REG_WDATA1, first);
    bus_write(REG_CTRL, {31'd0, DEV_1});
    bus_read(REG_STATUS, rd);
    check_reg("REG_STATUS", 32'd1, rd);
    bus_write(REG_WDATA1, ~first);
    bus_write(REG_CTRL, {31'd0, DEV_1});
    wait_idle();
    check_frame(frames_before + 1, first, 32);
    check_dev(DEV_1);

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* test/cf_spi_props.sv */
`default_nettype none

module cf_spi_props (
  input wire up_clk,
  input wire up_rstn,
  input wire up_req_i,
  input wire up_ack_i,
  input wire spi_cs0n_i,
  input wire spi_cs1n_i,
  input wire spi_clk_i,
  input wire spi_dout_i
);

  // ack may only rise in answer to a pending request.
  ack_needs_req: assert property (@(posedge up_clk) disable iff (!up_rstn)
    $rose(up_ack_i) |-> $past(up_req_i))
    else $error("host ack rose without a request");

  cs_exclusive: assert property (@(posedge up_clk) disable iff (!up_rstn)
    spi_cs0n_i || spi_cs1n_i)
    else $error("both chip selects are low");

  // the device samples on the rising edge, so data must hold while the clock is high.
  sd_stable: assert property (@(posedge up_clk) disable iff (!up_rstn)
    spi_clk_i |-> $stable(spi_dout_i))
    else $error("serial data changed while the serial clock was high");

  cs_high_in_reset: assert property (@(posedge up_clk)
    !up_rstn |=> (spi_cs0n_i && spi_cs1n_i))
    else $error("a chip select is low during reset");

endmodule

bind cf_spi_top cf_spi_props i_props (
  .up_clk     (up_clk),
  .up_rstn    (up_rstn),
  .up_req_i   (up_req_i),
  .up_ack_i   (up_ack_o),
  .spi_cs0n_i (spi_cs0n_o),
  .spi_cs1n_i (spi_cs1n_o),
  .spi_clk_i  (spi_clk_o),
  .spi_dout_i (spi_sd_o)
);

`default_nettype wire

/* verilog/cf_spi_top.sv */
`default_nettype none

`include "cf_spi_settings.svh"

module cf_spi_top (
  input  wire                                up_clk,
  input  wire                                up_rstn,
  input  wire                                up_req_i,
  input  wire cf_spi_regs_pkg::bus_op_e      up_op_i,
  input  wire cf_spi_regs_pkg::reg_addr_e    up_addr_i,
  input  wire        [`CF_SPI_DATA_W-1:0]    up_wdata_i,
  output wire                                up_ack_o,
  output wire        [`CF_SPI_DATA_W-1:0]    up_rdata_o,
  output wire                                spi_cs0n_o,
  output wire                                spi_cs1n_o,
  output wire                                spi_clk_o,
  output wire                                spi_sd_o,
  input  wire                                spi_sd_i
);

  import cf_spi_xfer_pkg::*;

  wire           xfer_req;
  wire           xfer_ack;
  dev_sel_e      xfer_dev;
  wire  [31:0]   xfer_frame;
  wire  [7:0]    rx_byte;

  // host side registers and start control.
  cf_spi_up_regs i_up_regs (
    .up_clk       (up_clk),
    .up_rstn      (up_rstn),
    .up_req_i     (up_req_i),
    .up_op_i      (up_op_i),
    .up_addr_i    (up_addr_i),
    .up_wdata_i   (up_wdata_i),
    .up_ack_o     (up_ack_o),
    .up_rdata_o   (up_rdata_o),
    .xfer_req_o   (xfer_req),
    .xfer_dev_o   (xfer_dev),
    .xfer_frame_o (xfer_frame),
    .xfer_ack_i   (xfer_ack),
    .rx_byte_i    (rx_byte)
  );

  // serial shift engine.
  cf_spi_engine i_engine (
    .up_clk       (up_clk),
    .up_rstn      (up_rstn),
    .xfer_req_i   (xfer_req),
    .xfer_dev_i   (xfer_dev),
    .xfer_frame_i (xfer_frame),
    .xfer_ack_o   (xfer_ack),
    .rx_byte_o    (rx_byte),
    .spi_cs0n_o   (spi_cs0n_o),
    .spi_cs1n_o   (spi_cs1n_o),
    .spi_clk_o    (spi_clk_o),
    .spi_sd_o     (spi_sd_o),
    .spi_sd_i     (spi_sd_i)
  );

endmodule

`default_nettype wire

/* verilog/cf_spi_engine.sv */
`default_nettype none

`include "cf_spi_settings.svh"

module cf_spi_engine (
  input  wire                              up_clk,
  input  wire                              up_rstn,
  input  wire                              xfer_req_i,
  input  wire cf_spi_xfer_pkg::dev_sel_e   xfer_dev_i,
  input  wire        [31:0]                xfer_frame_i,
  output logic                             xfer_ack_o,
  output logic       [7:0]                 rx_byte_o,
  output logic                             spi_cs0n_o,
  output logic                             spi_cs1n_o,
  output logic                             spi_clk_o,
  output logic                             spi_sd_o,
  input  wire                              spi_sd_i
);

  import cf_spi_xfer_pkg::*;

  localparam int CNT_W = `CF_SPI_CLK_DIV_LOG2;

  // last cycle of the low half and last cycle of the high half.
  localparam logic [CNT_W-1:0] CNT_RISE = {1'b0, {(CNT_W-1){1'b1}}};
  localparam logic [CNT_W-1:0] CNT_FALL = '1;

  engine_state_e    state;
  logic [CNT_W-1:0] clk_cnt;
  logic [5:0]       bit_cnt;
  logic [31:0]      shift_q;
  logic             rd_q;
  logic             rise;
  logic             fall;
  logic             start;
  logic             last_bit;

  assign rise     = (clk_cnt == CNT_RISE);
  assign fall     = (clk_cnt == CNT_FALL);
  assign last_bit = (bit_cnt == 6'd1);

  // a frame starts on a bit boundary of the free running divider.
  assign start = (state == ST_IDLE) & xfer_req_i & fall;

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      clk_cnt <= '0;
    end else begin
      clk_cnt <= clk_cnt + 1'b1;
    end
  end

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      state      <= ST_IDLE;
      spi_cs0n_o <= 1'b1;
      spi_cs1n_o <= 1'b1;
      spi_clk_o  <= 1'b0;
      spi_sd_o   <= 1'b0;
      xfer_ack_o <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (start) begin
            state      <= ST_SHIFT;
            spi_cs0n_o <= (xfer_dev_i != DEV_0);
            spi_cs1n_o <= (xfer_dev_i != DEV_1);
            spi_sd_o   <= xfer_frame_i[31];
          end
        end
        ST_SHIFT: begin
          if (rise) begin
            spi_clk_o <= 1'b1;
          end
          // data moves together with the falling edge, never while the clock is high.
          if (fall) begin
            spi_clk_o <= 1'b0;
            if (last_bit) begin
              state <= ST_HOLD;
            end else begin
              spi_sd_o <= shift_q[30];
            end
          end
        end
        ST_HOLD: begin
          // release chip select half a period after the last falling edge.
          if (rise) begin
            state      <= ST_DONE;
            spi_cs0n_o <= 1'b1;
            spi_cs1n_o <= 1'b1;
            spi_sd_o   <= 1'b0;
            xfer_ack_o <= 1'b1;
          end
        end
        ST_DONE: begin
          if (!xfer_req_i) begin
            state      <= ST_IDLE;
            xfer_ack_o <= 1'b0;
          end
        end
      endcase
    end
  end

  always_ff @(posedge up_clk) begin
    if (start) begin
      shift_q   <= xfer_frame_i;
      bit_cnt   <= (xfer_dev_i == DEV_1) ? 6'd32 : 6'd16;
      rd_q      <= (xfer_dev_i == DEV_0) & xfer_frame_i[31];
      rx_byte_o <= 8'd0;
    end else if (state == ST_SHIFT) begin
      // read data is taken at each rising edge of the last eight bits.
      if (rise && rd_q && (bit_cnt <= 6'd8)) begin
        rx_byte_o <= {rx_byte_o[6:0], spi_sd_i};
      end
      if (fall && !last_bit) begin
        shift_q <= {shift_q[30:0], 1'b0};
        bit_cnt <= bit_cnt - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/cf_spi_up_regs.sv */
`default_nettype none

`include "cf_spi_settings.svh"

module cf_spi_up_regs (
  input  wire                                up_clk,
  input  wire                                up_rstn,
  input  wire                                up_req_i,
  input  wire cf_spi_regs_pkg::bus_op_e      up_op_i,
  input  wire cf_spi_regs_pkg::reg_addr_e    up_addr_i,
  input  wire        [`CF_SPI_DATA_W-1:0]    up_wdata_i,
  output logic                               up_ack_o,
  output logic       [`CF_SPI_DATA_W-1:0]    up_rdata_o,
  output logic                               xfer_req_o,
  output cf_spi_xfer_pkg::dev_sel_e          xfer_dev_o,
  output logic       [31:0]                  xfer_frame_o,
  input  wire                                xfer_ack_i,
  input  wire        [7:0]                   rx_byte_i
);

  import cf_spi_regs_pkg::*;
  import cf_spi_xfer_pkg::*;

  logic [15:0]               wdata0;
  logic [`CF_SPI_DATA_W-1:0] wdata1;
  logic [7:0]                rdata;
  logic [`CF_SPI_DATA_W-1:0] rdata_mux;
  logic                      busy;
  logic                      access;
  logic                      start;
  dev_sel_e                  new_dev;

  // an access is taken once, on the first edge that sees req with ack still low.
  assign access  = up_req_i & ~up_ack_o;
  assign busy    = xfer_req_o | xfer_ack_i;
  assign new_dev = dev_sel_e'(up_wdata_i[0]);

  // a start while busy is dropped.
  assign start = access & (up_op_i == OP_WRITE) & (up_addr_i == REG_CTRL) & ~busy;

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      up_ack_o <= 1'b0;
    end else if (access) begin
      up_ack_o <= 1'b1;
    end else if (!up_req_i) begin
      up_ack_o <= 1'b0;
    end
  end

  always_ff @(posedge up_clk) begin
    if (access && (up_op_i == OP_WRITE)) begin
      case (up_addr_i)
        REG_WDATA0: wdata0 <= up_wdata_i[15:0];
        REG_WDATA1: wdata1 <= up_wdata_i;
        default: begin
        end
      endcase
    end
  end

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      xfer_req_o <= 1'b0;
    end else if (start) begin
      xfer_req_o <= 1'b1;
    end else if (xfer_ack_i) begin
      xfer_req_o <= 1'b0;
    end
  end

  // frames are left aligned, so device 0 sends its half-word first.
  always_ff @(posedge up_clk) begin
    if (start) begin
      xfer_dev_o   <= new_dev;
      xfer_frame_o <= (new_dev == DEV_1) ? wdata1 : {wdata0, 16'd0};
    end
  end

  // only a device 0 frame with bit 31 set returns data.
  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      rdata <= 8'd0;
    end else if (xfer_req_o && xfer_ack_i && (xfer_dev_o == DEV_0) && xfer_frame_o[31]) begin
      rdata <= rx_byte_i;
    end
  end

  always_comb begin
    case (up_addr_i)
      REG_WDATA0: rdata_mux = {{(`CF_SPI_DATA_W-16){1'b0}}, wdata0};
      REG_WDATA1: rdata_mux = wdata1;
      REG_CTRL:   rdata_mux = {{(`CF_SPI_DATA_W-1){1'b0}}, xfer_dev_o};
      REG_STATUS: rdata_mux = {{(`CF_SPI_DATA_W-1){1'b0}}, busy};
      REG_RDATA:  rdata_mux = {{(`CF_SPI_DATA_W-8){1'b0}}, rdata};
      default:    rdata_mux = '0;
    endcase
  end

  // read data is held for as long as ack stays high.
  always_ff @(posedge up_clk) begin
    if (access && (up_op_i == OP_READ)) begin
      up_rdata_o <= rdata_mux;
    end
  end

endmodule

`default_nettype wire

/* verilog/cf_spi_xfer_pkg.sv */
`default_nettype none

package cf_spi_xfer_pkg;

  typedef enum logic {
    DEV_0 = 1'b0,
    DEV_1 = 1'b1
  } dev_sel_e;

  // shift engine states.
  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    ST_SHIFT = 2'd1,
    ST_HOLD  = 2'd2,
    ST_DONE  = 2'd3
  } engine_state_e;

endpackage

`default_nettype wire

/* verilog/cf_spi_regs_pkg.sv */
`default_nettype none

`include "cf_spi_settings.svh"

package cf_spi_regs_pkg;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } bus_op_e;

  // register map of the host port.
  typedef enum logic [`CF_SPI_ADDR_W-1:0] {
    REG_WDATA0 = 0,
    REG_WDATA1 = 1,
    REG_CTRL   = 2,
    REG_STATUS = 3,
    REG_RDATA  = 4
  } reg_addr_e;

endpackage

`default_nettype wire

/* verilog/cf_spi_settings.svh */
`ifndef CF_SPI_SETTINGS_SVH
`define CF_SPI_SETTINGS_SVH

// log2 of the up_clk cycles in one serial clock period.
`define CF_SPI_CLK_DIV_LOG2 3

// host register port widths.
`define CF_SPI_ADDR_W 3
`define CF_SPI_DATA_W 32

`endif
